// File: verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// sizing of the on-chip memories, in 32-bit words
`define IMEM_DEPTH 64 // program store
`define DMEM_DEPTH 64 // data store

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// jal return address goes here
`define LINK_REG 5'd31

`endif

// File: verilog/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t; // data word or byte address
  typedef logic [4:0]  reg_addr_t; // gpr index

  // primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    op_special = 6'h00, // r-type, decoded by funct
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addi    = 6'h08,
    op_slti    = 6'h0a,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  // r-type function field, bits 5:0
  typedef enum logic [5:0] {
    fn_jr  = 6'h08,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_e;

  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] shamt; // unused, no shifts here
    funct_e    funct;
  } r_format_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm; // offset or immediate operand
  } i_format_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [25:0] target; // word index within the 256MB region
  } j_format_t;

  // one fetched word, three ways of reading it
  typedef union packed {
    r_format_t r;
    i_format_t i;
    j_format_t j;
  } instr_u;

endpackage

// File: verilog/core_pkg.sv
`include "cpu_params.svh"

package core_pkg;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub, // also the beq/bne compare
    alu_and,
    alu_or,
    alu_slt  // signed
  } alu_op_e;

  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e; // write-back source
  typedef enum logic [1:0] {wadr_rt, wadr_rd, wadr_link} wadr_sel_e; // destination gpr

  // everything the decoder hands to the datapath
  typedef struct packed {
    pc_sel_e   pc_sel;
    logic      branch_ne;   // bne flavour
    logic      is_branch;
    logic      sign_ext;    // else zero extend
    logic      alu_src_imm; // operand b from immediate
    alu_op_e   alu_op;
    logic      dm_wen;
    logic      rf_wen;
    wb_sel_e   wb_sel;
    wadr_sel_e wadr_sel;
  } ctrl_t;

  // register file commit, 38 bits
  typedef struct packed {
    logic               wen;
    isa_pkg::reg_addr_t addr;
    isa_pkg::word_t     data;
  } rf_write_t;

  typedef struct packed {
    logic                             wen;
    logic [$clog2(`DMEM_DEPTH)-1:0]   addr; // word address
    isa_pkg::word_t                   data;
  } dm_write_t;

  // program load port, used only under reset
  typedef struct packed {
    logic                             wen;
    logic [$clog2(`IMEM_DEPTH)-1:0]   addr; // word address
    isa_pkg::word_t                   data;
  } imem_load_t;

endpackage

// File: verilog/controller.sv
`timescale 1ns/1ps

module controller (
  input  isa_pkg::instr_u instr,
  output core_pkg::ctrl_t ctrl
);

  always_comb begin
    // idle bundle, also what an unknown code gets
    ctrl.pc_sel      = core_pkg::pc_seq;
    ctrl.branch_ne   = 1'b0;
    ctrl.is_branch   = 1'b0;
    ctrl.sign_ext    = 1'b1;
    ctrl.alu_src_imm = 1'b0;
    ctrl.alu_op      = core_pkg::alu_add;
    ctrl.dm_wen      = 1'b0;
    ctrl.rf_wen      = 1'b0;
    ctrl.wb_sel      = core_pkg::wb_alu;
    ctrl.wadr_sel    = core_pkg::wadr_rt;

    case (instr.r.opcode)
      isa_pkg::op_special: begin
        ctrl.wadr_sel = core_pkg::wadr_rd; // r-type writes rd
        case (instr.r.funct)
          isa_pkg::fn_add: begin
            ctrl.rf_wen = 1'b1;
          end
          isa_pkg::fn_sub: begin
            ctrl.rf_wen = 1'b1;
            ctrl.alu_op = core_pkg::alu_sub;
          end
          isa_pkg::fn_and: begin
            ctrl.rf_wen = 1'b1;
            ctrl.alu_op = core_pkg::alu_and;
          end
          isa_pkg::fn_or: begin
            ctrl.rf_wen = 1'b1;
            ctrl.alu_op = core_pkg::alu_or;
          end
          isa_pkg::fn_slt: begin
            ctrl.rf_wen = 1'b1;
            ctrl.alu_op = core_pkg::alu_slt;
          end
          isa_pkg::fn_jr: ctrl.pc_sel = core_pkg::pc_reg; // target from rs
          default: ; // unsupported funct, falls through as nop
        endcase
      end
      isa_pkg::op_j: ctrl.pc_sel = core_pkg::pc_jump;
      isa_pkg::op_jal: begin
        ctrl.pc_sel   = core_pkg::pc_jump;
        ctrl.rf_wen   = 1'b1;
        ctrl.wb_sel   = core_pkg::wb_pc4; // return address
        ctrl.wadr_sel = core_pkg::wadr_link;
      end
      isa_pkg::op_beq, isa_pkg::op_bne: begin
        ctrl.pc_sel    = core_pkg::pc_branch;
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = (instr.i.opcode == isa_pkg::op_bne);
        ctrl.alu_op    = core_pkg::alu_sub; // rs - rt, zero on equal
      end
      isa_pkg::op_addi, isa_pkg::op_slti, isa_pkg::op_andi, isa_pkg::op_ori: begin
        ctrl.rf_wen      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        case (instr.i.opcode)
          isa_pkg::op_slti: ctrl.alu_op = core_pkg::alu_slt;
          isa_pkg::op_andi: ctrl.alu_op = core_pkg::alu_and;
          isa_pkg::op_ori:  ctrl.alu_op = core_pkg::alu_or;
          default:          ctrl.alu_op = core_pkg::alu_add;
        endcase
        // logical immediates are zero extended
        ctrl.sign_ext = !(instr.i.opcode inside {isa_pkg::op_andi, isa_pkg::op_ori});
      end
      isa_pkg::op_lw: begin
        ctrl.rf_wen      = 1'b1;
        ctrl.alu_src_imm = 1'b1; // base + offset
        ctrl.wb_sel      = core_pkg::wb_mem;
      end
      isa_pkg::op_sw: begin
        ctrl.dm_wen      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      default: ; // unknown opcode
    endcase
  end

  // stores never write back, checked on every instruction change
  a_single_commit: assert property (@(instr) !(ctrl.dm_wen && ctrl.rf_wen));

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  core_pkg::ctrl_t  ctrl,
  input  isa_pkg::instr_u  instr,
  input  isa_pkg::word_t   rs_data, // jr target
  input  logic             zero,
  output isa_pkg::word_t   pc,
  output isa_pkg::word_t   pc_plus4
);

  isa_pkg::word_t branch_target;
  isa_pkg::word_t jump_target;
  isa_pkg::word_t pc_next;
  logic           taken;

  assign pc_plus4 = pc + 32'd4;
  // offset counts words, relative to the delay-free pc+4
  assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.target, 2'b00}; // same region
  assign taken         = ctrl.is_branch && (zero != ctrl.branch_ne); // beq on zero, bne otherwise

  always_comb begin
    case (ctrl.pc_sel)
      core_pkg::pc_branch: pc_next = taken ? branch_target : pc_plus4;
      core_pkg::pc_jump:   pc_next = jump_target;
      core_pkg::pc_reg:    pc_next = rs_data;
      default:             pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next; // one instruction per edge
    end
  end

  // a bad jr value would show up one cycle later as a misaligned pc
  a_pc_aligned: assert property (@(posedge clk) rst_n |=> pc[1:0] == 2'b00);

endmodule

// File: verilog/instruction_memory.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module instruction_memory (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::imem_load_t load,
  input  isa_pkg::word_t       pc,
  output isa_pkg::instr_u      instr
);

  localparam int aw = $clog2(`IMEM_DEPTH); // word index width

  isa_pkg::word_t mem [`IMEM_DEPTH];

  // program download, only while the core is held
  always_ff @(posedge clk) begin
    if (!rst_n && load.wen) begin
      mem[load.addr] <= load.data;
    end
  end

  assign instr = mem[pc[aw+1:2]]; // byte pc to word index

  // loading into a running core would corrupt fetch
  a_load_in_reset: assert property (@(posedge clk) rst_n |-> !load.wen);

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::ctrl_t     ctrl,
  input  isa_pkg::instr_u     instr,
  input  isa_pkg::word_t      alu_result,
  input  isa_pkg::word_t      mem_data,
  input  isa_pkg::word_t      pc_plus4,
  output isa_pkg::word_t      rs_data,
  output isa_pkg::word_t      rt_data,
  output core_pkg::rf_write_t rf_write
);

  isa_pkg::word_t     regs [32];
  isa_pkg::reg_addr_t wadr;
  isa_pkg::word_t     wdata;

  always_comb begin
    case (ctrl.wadr_sel)
      core_pkg::wadr_rd:   wadr = instr.r.rd;
      core_pkg::wadr_link: wadr = `LINK_REG; // jal
      default:             wadr = instr.r.rt; // i-type
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_mem: wdata = mem_data; // lw
      core_pkg::wb_pc4: wdata = pc_plus4; // link value
      default:          wdata = alu_result;
    endcase
  end

  // commit enable, r0 writes dropped here
  assign rf_write.wen  = rst_n && ctrl.rf_wen && (wadr != 5'd0);
  assign rf_write.addr = wadr;
  assign rf_write.data = wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (rf_write.wen) begin
      regs[rf_write.addr] <= rf_write.data;
    end
  end

  assign rs_data = regs[instr.r.rs]; // r0 stays zero, never written
  assign rt_data = regs[instr.r.rt];

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  core_pkg::ctrl_t ctrl,
  input  isa_pkg::instr_u instr,
  input  isa_pkg::word_t  rs_data,
  input  isa_pkg::word_t  rt_data,
  output isa_pkg::word_t  alu_result,
  output logic            zero
);

  isa_pkg::word_t imm_ext;
  isa_pkg::word_t op_b;

  // andi and ori want the upper half clear
  assign imm_ext = ctrl.sign_ext ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                 : {16'h0000, instr.i.imm};

  assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb begin
    case (ctrl.alu_op)
      core_pkg::alu_add: alu_result = rs_data + op_b; // also lw/sw address
      core_pkg::alu_sub: alu_result = rs_data - op_b;
      core_pkg::alu_and: alu_result = rs_data & op_b;
      core_pkg::alu_or:  alu_result = rs_data | op_b;
      core_pkg::alu_slt: alu_result = {31'd0, $signed(rs_data) < $signed(op_b)};
      default:           alu_result = '0;
    endcase
  end

  assign zero = (alu_result == '0); // branch compare result

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module data_memory (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::ctrl_t     ctrl,
  input  isa_pkg::word_t      addr, // byte address from the alu
  input  isa_pkg::word_t      wdata,
  output isa_pkg::word_t      rdata,
  output core_pkg::dm_write_t dm_write
);

  localparam int aw = $clog2(`DMEM_DEPTH);

  isa_pkg::word_t mem [`DMEM_DEPTH];

  assign dm_write.wen  = rst_n && ctrl.dm_wen; // held off during reset
  assign dm_write.addr = addr[aw+1:2];
  assign dm_write.data = wdata; // rt value

  always_ff @(posedge clk) begin
    if (dm_write.wen) begin
      mem[dm_write.addr] <= dm_write.data;
    end
  end

  assign rdata = mem[addr[aw+1:2]]; // lw data, same cycle

  // word accesses only, low bits would be silently dropped
  a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.dm_wen |-> addr[1:0] == 2'b00);

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::imem_load_t imem_load,
  output isa_pkg::word_t       pc,
  output core_pkg::rf_write_t  rf_write,
  output core_pkg::dm_write_t  dm_write
);

  isa_pkg::instr_u instr; // current instruction, all formats
  core_pkg::ctrl_t ctrl;

  isa_pkg::word_t  pc_plus4;
  isa_pkg::word_t  rs_data;
  isa_pkg::word_t  rt_data;
  isa_pkg::word_t  alu_result; // also data memory address
  isa_pkg::word_t  mem_rdata;
  logic            zero;

  instruction_memory u_imem (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (imem_load),
    .pc    (pc),
    .instr (instr)
  );

  controller u_ctrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  fetch_unit u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .instr    (instr),
    .rs_data  (rs_data),
    .zero     (zero),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  register_file u_rf (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .instr      (instr),
    .alu_result (alu_result),
    .mem_data   (mem_rdata),
    .pc_plus4   (pc_plus4),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .rf_write   (rf_write)
  );

  execute_unit u_exec (
    .ctrl       (ctrl),
    .instr      (instr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .alu_result (alu_result),
    .zero       (zero)
  );

  data_memory u_dmem (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .addr     (alu_result),
    .wdata    (rt_data), // sw stores rt
    .rdata    (mem_rdata),
    .dm_write (dm_write)
  );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_ns = 20 // 40 ns period
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(half_ns) clk = ~clk; // free running, stopped by $finish

endmodule

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;

  localparam int im_aw      = $clog2(`IMEM_DEPTH);
  localparam int dm_aw      = $clog2(`DMEM_DEPTH);
  localparam int last_word  = `IMEM_DEPTH - 1; // self jump lives here
  localparam int run_cycles = 400;

  logic                 clk;
  logic                 rst_n;
  core_pkg::imem_load_t imem_load;
  isa_pkg::word_t       pc;
  core_pkg::rf_write_t  rf_write;
  core_pkg::dm_write_t  dm_write;

  isa_pkg::word_t prog   [`IMEM_DEPTH]; // generated program image
  isa_pkg::word_t m_regs [32];          // reference model state
  isa_pkg::word_t m_dmem [`DMEM_DEPTH];
  isa_pkg::word_t m_pc;

  integer seed;
  int     cycle;
  int     pc_errs, rf_errs, dm_errs, other_errs;

  tb_clock #(.half_ns(20)) u_clk (.clk(clk));

  cpu uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_load (imem_load),
    .pc        (pc),
    .rf_write  (rf_write),
    .dm_write  (dm_write)
  );

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic isa_pkg::word_t enc_r(input isa_pkg::funct_e fn,
      input isa_pkg::reg_addr_t rs, input isa_pkg::reg_addr_t rt, input isa_pkg::reg_addr_t rd);
    return {6'h00, rs, rt, rd, 5'd0, fn}; // special opcode with zero shamt
  endfunction

  function automatic isa_pkg::word_t enc_i(input isa_pkg::opcode_e op,
      input isa_pkg::reg_addr_t rs, input isa_pkg::reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic isa_pkg::word_t enc_j(input isa_pkg::opcode_e op, input int word_idx);
    return {op, 26'(word_idx)}; // program sits in the first 256MB region
  endfunction

  // random body between a store prefix and the final self jump
  task automatic build_program();
    int                 i;
    int                 tgt;
    int unsigned        k;
    isa_pkg::reg_addr_t s, t, d;
    logic [15:0]        imm, off;
    logic               landed [`IMEM_DEPTH]; // words some branch or jump can reach
    for (i = 0; i < `IMEM_DEPTH; i++) landed[i] = 1'b0;
    for (i = 0; i < 8; i++) begin
      prog[i] = enc_i(isa_pkg::op_sw, 5'd0, 5'd0, 16'(i * 4)); // clear the scratch words
    end
    i = 8;
    while (i < last_word) begin
      k   = rnd(16);
      s   = isa_pkg::reg_addr_t'(rnd(32));
      t   = isa_pkg::reg_addr_t'(rnd(32));
      d   = isa_pkg::reg_addr_t'(rnd(30)); // r0 allowed but r30 kept for jr
      imm = 16'(rnd(65536));
      off = 16'(rnd(8) * 4); // scratch words 0..7 only
      tgt = i + 1 + rnd(4); // short forward hops
      if (tgt > last_word) tgt = last_word;
      // no room for the ori/jr pair or a hop would enter the jr past its ori
      if (k == 15 && (i > last_word - 2 || landed[i + 1])) k = 0;
      case (k)
        0:  prog[i] = enc_r(isa_pkg::fn_add, s, t, d);
        1:  prog[i] = enc_r(isa_pkg::fn_sub, s, t, d);
        2:  prog[i] = enc_r(isa_pkg::fn_and, s, t, d);
        3:  prog[i] = enc_r(isa_pkg::fn_or, s, t, d);
        4:  prog[i] = enc_r(isa_pkg::fn_slt, s, t, d);
        5:  prog[i] = enc_i(isa_pkg::op_addi, s, d, imm);
        6:  prog[i] = enc_i(isa_pkg::op_slti, s, d, imm);
        7:  prog[i] = enc_i(isa_pkg::op_andi, s, d, imm);
        8:  prog[i] = enc_i(isa_pkg::op_ori, s, d, imm);
        9:  prog[i] = enc_i(isa_pkg::op_lw, 5'd0, d, off);
        10: prog[i] = enc_i(isa_pkg::op_sw, 5'd0, t, off);
        11: prog[i] = enc_i(isa_pkg::op_beq, s, t, 16'(tgt - i - 1));
        12: prog[i] = enc_i(isa_pkg::op_bne, s, t, 16'(tgt - i - 1));
        13: prog[i] = enc_j(isa_pkg::op_j, tgt);
        14: prog[i] = enc_j(isa_pkg::op_jal, tgt);
        default: begin
          if (tgt < i + 2) tgt = i + 2; // must skip past the jr itself
          prog[i] = enc_i(isa_pkg::op_ori, 5'd0, 5'd30, 16'(tgt * 4));
          i++;
          prog[i] = enc_r(isa_pkg::fn_jr, 5'd30, 5'd0, 5'd0);
        end
      endcase
      if (k >= 11) landed[tgt] = 1'b1; // taken or not, this word may be entered directly
      i++;
    end
    prog[last_word] = enc_j(isa_pkg::op_j, last_word); // park here
  endtask

  // ISA view of the word at m_pc without side effects
  task automatic predict(output core_pkg::rf_write_t erf, output core_pkg::dm_write_t edm,
                         output isa_pkg::word_t npc);
    isa_pkg::instr_u ins;
    isa_pkg::word_t  a, b, simm, zimm, p4, ea;
    ins  = prog[m_pc[im_aw+1:2]];
    a    = m_regs[ins.r.rs];
    b    = m_regs[ins.r.rt];
    simm = {{16{ins.i.imm[15]}}, ins.i.imm};
    zimm = {16'h0000, ins.i.imm};
    p4   = m_pc + 32'd4;
    ea   = a + simm; // lw/sw address
    npc  = p4;
    erf  = '0;
    edm  = '0;
    erf.wen  = 1'b1;
    erf.addr = ins.i.rt; // i-type destination unless changed below
    case (ins.r.opcode)
      isa_pkg::op_special: begin
        erf.addr = ins.r.rd;
        case (ins.r.funct)
          isa_pkg::fn_add: erf.data = a + b;
          isa_pkg::fn_sub: erf.data = a - b;
          isa_pkg::fn_and: erf.data = a & b;
          isa_pkg::fn_or:  erf.data = a | b;
          isa_pkg::fn_slt: erf.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: begin // jr
            erf.wen = 1'b0;
            npc     = a;
          end
        endcase
      end
      isa_pkg::op_addi: erf.data = a + simm;
      isa_pkg::op_slti: erf.data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      isa_pkg::op_andi: erf.data = a & zimm; // logical ops zero extend
      isa_pkg::op_ori:  erf.data = a | zimm;
      isa_pkg::op_lw:   erf.data = m_dmem[ea[dm_aw+1:2]];
      isa_pkg::op_sw: begin
        erf.wen  = 1'b0;
        edm.wen  = 1'b1;
        edm.addr = ea[dm_aw+1:2];
        edm.data = b;
      end
      isa_pkg::op_beq, isa_pkg::op_bne: begin
        erf.wen = 1'b0;
        if ((a == b) == (ins.i.opcode == isa_pkg::op_beq)) npc = p4 + {simm[29:0], 2'b00};
      end
      isa_pkg::op_j, isa_pkg::op_jal: begin
        erf.wen  = (ins.j.opcode == isa_pkg::op_jal); // only jal links
        erf.addr = `LINK_REG;
        erf.data = p4;
        npc      = {p4[31:28], ins.j.target, 2'b00};
      end
      default: erf.wen = 1'b0;
    endcase
    if (erf.addr == 5'd0) erf.wen = 1'b0; // r0 hardwired
  endtask

  task automatic check_pc(input isa_pkg::word_t exp, input isa_pkg::word_t act);
    if (act !== exp) begin
      pc_errs++;
      $display("ERR pc cycle %0d exp %08h got %08h", cycle, exp, act);
    end
  endtask

  // addr and data only matter when a write is expected
  task automatic check_rf_write(input core_pkg::rf_write_t exp, input core_pkg::rf_write_t act);
    if (act.wen !== exp.wen || (exp.wen && (act.addr !== exp.addr || act.data !== exp.data))) begin
      rf_errs++;
      $display("ERR rf_write cycle %0d exp wen %h addr %h data %08h got wen %h addr %h data %08h",
               cycle, exp.wen, exp.addr, exp.data, act.wen, act.addr, act.data);
    end
  endtask

  task automatic check_dm_write(input core_pkg::dm_write_t exp, input core_pkg::dm_write_t act);
    if (act.wen !== exp.wen || (exp.wen && (act.addr !== exp.addr || act.data !== exp.data))) begin
      dm_errs++;
      $display("ERR dm_write cycle %0d exp wen %h addr %h data %08h got wen %h addr %h data %08h",
               cycle, exp.wen, exp.addr, exp.data, act.wen, act.addr, act.data);
    end
  endtask

  // one reset cycle sampled 5 ns before the edge
  task automatic reset_cycle();
    #15;
    check_pc(`RESET_PC, pc);
    check_rf_write('0, rf_write);
    check_dm_write('0, dm_write);
    @(negedge clk);
  endtask

  // checks one retired instruction and then commits it to the model
  task automatic run_cycle();
    core_pkg::rf_write_t erf;
    core_pkg::dm_write_t edm;
    isa_pkg::word_t      npc;
    #15;
    predict(erf, edm, npc);
    check_pc(m_pc, pc);
    check_rf_write(erf, rf_write);
    check_dm_write(edm, dm_write);
    if (erf.wen) m_regs[erf.addr] = erf.data;
    if (edm.wen) m_dmem[edm.addr] = edm.data;
    m_pc = npc;
    cycle++;
    @(negedge clk);
  endtask

  initial begin
    int n;
    seed       = 32'h21c;
    rst_n      = 1'b0;
    imem_load  = '0;
    cycle      = 0;
    pc_errs    = 0;
    rf_errs    = 0;
    dm_errs    = 0;
    other_errs = 0;
    m_pc       = `RESET_PC;
    for (n = 0; n < 32; n++) m_regs[n] = '0;
    build_program();
    @(posedge clk);
    @(negedge clk);
    for (n = 0; n < 16; n++) reset_cycle(); // plain reset
    for (n = 0; n < `IMEM_DEPTH; n++) begin // download while the core is still held
      imem_load.wen  = 1'b1;
      imem_load.addr = im_aw'(n);
      imem_load.data = prog[n];
      reset_cycle();
    end
    imem_load = '0;
    rst_n     = 1'b1;
    // walk the program until it parks on the last word
    while (m_pc != last_word * 4 && cycle < run_cycles) run_cycle();
    if (m_pc != last_word * 4) begin
      other_errs++;
      $display("program did not reach its final jump within %0d cycles", run_cycles);
    end
    while (cycle < run_cycles) run_cycle(); // keep checking the parked loop
    $display("errors pc %0d rf_write %0d dm_write %0d other %0d",
             pc_errs, rf_errs, dm_errs, other_errs);
    if (pc_errs + rf_errs + dm_errs + other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/controller.sv
verilog/fetch_unit.sv
verilog/instruction_memory.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/data_memory.sv
verilog/cpu.sv
verif/tb_clock.sv
verif/cpu_tb.sv

// File: Bender.yml
package:
  name: mips_single_cycle

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isa_pkg.sv
      - verilog/core_pkg.sv
      - verilog/controller.sv
      - verilog/fetch_unit.sv
      - verilog/instruction_memory.sv
      - verilog/register_file.sv
      - verilog/execute_unit.sv
      - verilog/data_memory.sv
      - verilog/cpu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clock.sv
      - verif/cpu_tb.sv
